// File: Bender.yml
package:
  name: mem_subsys

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_types_pkg.sv
      - hdl/ex_mem_reg.sv
      - hdl/load_extender.sv
      - hdl/mem_stage.sv
      - hdl/data_ram.sv
      - hdl/mem_subsys_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_clk_gen.sv
      - test/tb_mem_subsys.sv

// File: all.f
+incdir+hdl
hdl/mem_types_pkg.sv
hdl/ex_mem_reg.sv
hdl/load_extender.sv
hdl/mem_stage.sv
hdl/data_ram.sv
hdl/mem_subsys_top.sv
test/tb_clk_gen.sv
test/tb_mem_subsys.sv

// File: hdl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module data_ram #(
    parameter int ADDR_BITS = `RAM_ADDR_BITS
) (
    input  wire logic                   CLK,
    input  wire logic                   nRST,
    input  wire logic                   ren,
    input  wire logic                   wen,
    input  wire logic [ADDR_BITS-1:0]   addr,
    input  wire logic [`DATA_W/8-1:0]   byte_en,
    input  wire logic [`DATA_W-1:0]     wdata,
    output logic [`DATA_W-1:0]          rdata,
    output logic                        busy
);

    logic [`DATA_W-1:0] mem [2**ADDR_BITS];
    logic               done;

    // First cycle of a request is busy, the second completes it
    assign busy = (ren || wen) && !done;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            done <= 1'b0;
        end else begin
            done <= (ren || wen) && !done;
        end
    end

    // Array access happens once, at the end of the busy cycle
    always_ff @(posedge CLK) begin
        if (wen && !done) begin
            for (int i = 0; i < `DATA_W/8; i++) begin
                if (byte_en[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
        if (ren && !done) begin
            rdata <= mem[addr];
        end
    end

    // The stage issues one kind of request at a time
    a_rd_wr_excl: assert property (@(posedge CLK) disable iff (!nRST)
        !(ren && wen));

endmodule

`default_nettype wire

// File: hdl/ex_mem_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module ex_mem_reg (
    input  wire logic                     CLK,
    input  wire logic                     nRST,
    input  wire logic                     stall,
    input  wire logic                     in_valid,
    input  wire logic                     in_dren,
    input  wire logic                     in_dwen,
    input  mem_types_pkg::mem_size_t      in_size,
    input  mem_types_pkg::wb_sel_t        in_wb_sel,
    input  wire logic                     in_reg_write,
    input  wire logic [`REG_IDX_W-1:0]    in_rd,
    input  wire logic [`DATA_W-1:0]       in_alu_out,
    input  wire logic [`DATA_W-1:0]       in_rs2_data,
    input  wire logic [`DATA_W-1:0]       in_pc4,
    input  wire logic [`DATA_W-1:0]       in_imm_u,
    output logic                          m_valid,
    output logic                          m_dren,
    output logic                          m_dwen,
    output mem_types_pkg::mem_size_t      m_size,
    output mem_types_pkg::wb_sel_t        m_wb_sel,
    output logic                          m_reg_write,
    output logic [`REG_IDX_W-1:0]         m_rd,
    output logic [`DATA_W-1:0]            m_alu_out,
    output logic [`DATA_W-1:0]            m_rs2_data,
    output logic [`DATA_W-1:0]            m_pc4,
    output logic [`DATA_W-1:0]            m_imm_u
);

    // Control bits; a bubble enters when nothing is offered
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            m_valid     <= 1'b0;
            m_dren      <= 1'b0;
            m_dwen      <= 1'b0;
            m_reg_write <= 1'b0;
        end else if (!stall) begin
            m_valid     <= in_valid;
            m_dren      <= in_valid && in_dren;
            m_dwen      <= in_valid && in_dwen;
            m_reg_write <= in_valid && in_reg_write;
        end
    end

    // Payload only moves on an accepted entry
    always_ff @(posedge CLK) begin
        if (!stall && in_valid) begin
            m_size     <= in_size;
            m_wb_sel   <= in_wb_sel;
            m_rd       <= in_rd;
            m_alu_out  <= in_alu_out;
            m_rs2_data <= in_rs2_data;
            m_pc4      <= in_pc4;
            m_imm_u    <= in_imm_u;
        end
    end

    // An accepted instruction is a load or a store, never both
    a_ld_st_excl: assert property (@(posedge CLK) disable iff (!nRST)
        (in_valid && !stall) |=> !(m_valid && m_dren && m_dwen));

endmodule

`default_nettype wire

// File: hdl/load_extender.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module load_extender (
    input  wire logic [`DATA_W-1:0]   rdata,
    input  mem_types_pkg::mem_size_t  size,
    input  wire logic [1:0]           offset,
    output logic [`DATA_W-1:0]        load_data
);

    mem_types_pkg::data_word_u word;
    logic [7:0]                sel_byte;
    logic [15:0]               sel_half;

    assign word = rdata;

    // Byte lane equals the offset, halfword picked by offset bit 1
    assign sel_byte = word.lanes[offset];
    assign sel_half = word.halves[offset[1]];

    always_comb begin
        case (size)
            mem_types_pkg::LB: begin
                load_data = {{(`DATA_W-8){sel_byte[7]}}, sel_byte};
            end
            mem_types_pkg::LBU: begin
                load_data = {{(`DATA_W-8){1'b0}}, sel_byte};
            end
            mem_types_pkg::LH: begin
                load_data = {{(`DATA_W-16){sel_half[15]}}, sel_half};
            end
            mem_types_pkg::LHU: begin
                load_data = {{(`DATA_W-16){1'b0}}, sel_half};
            end
            // Full word passes through
            default: begin
                load_data = rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Data and address word width
`define DATA_W 32

// Word address bits of the data RAM, 8 gives 1 KiB
`define RAM_ADDR_BITS 8

// Destination register index width
`define REG_IDX_W 5

`endif

// File: hdl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_stage (
    input  wire logic                     m_valid,
    input  wire logic                     m_dren,
    input  wire logic                     m_dwen,
    input  mem_types_pkg::mem_size_t      m_size,
    input  mem_types_pkg::wb_sel_t        m_wb_sel,
    input  wire logic                     m_reg_write,
    input  wire logic [`REG_IDX_W-1:0]    m_rd,
    input  wire logic [`DATA_W-1:0]       m_alu_out,
    input  wire logic [`DATA_W-1:0]       m_rs2_data,
    input  wire logic [`DATA_W-1:0]       m_pc4,
    input  wire logic [`DATA_W-1:0]       m_imm_u,
    input  wire logic                     busy,
    input  wire logic [`DATA_W-1:0]       load_data,
    output logic                          ren,
    output logic                          wen,
    output logic [`RAM_ADDR_BITS-1:0]     addr,
    output logic [`DATA_W/8-1:0]          byte_en,
    output logic [`DATA_W-1:0]            wdata,
    output logic                          stall,
    output logic                          wb_valid,
    output logic [`REG_IDX_W-1:0]         wb_rd,
    output logic [`DATA_W-1:0]            wb_data,
    output logic                          mal_l,
    output logic                          mal_s
);

    logic [1:0] offset;
    logic       mal_addr;

    assign offset = m_alu_out[1:0];
    assign addr   = m_alu_out[`RAM_ADDR_BITS+1:2];

    // Little-endian lanes with the upper half at offset 2
    always_comb begin
        case (m_size)
            mem_types_pkg::LB, mem_types_pkg::LBU: begin
                byte_en  = 4'b0001 << offset;
                mal_addr = 1'b0;
            end
            mem_types_pkg::LH, mem_types_pkg::LHU: begin
                byte_en  = offset[1] ? 4'b1100 : 4'b0011;
                mal_addr = offset[0];
            end
            mem_types_pkg::LW: begin
                byte_en  = 4'b1111;
                mal_addr = (offset != 2'b00);
            end
            default: begin
                byte_en  = 4'b0000;
                mal_addr = 1'b0;
            end
        endcase
    end

    // Store data copied into every lane it could land on
    always_comb begin
        case (m_size)
            mem_types_pkg::LB, mem_types_pkg::LBU: wdata = {4{m_rs2_data[7:0]}};
            mem_types_pkg::LH, mem_types_pkg::LHU: wdata = {2{m_rs2_data[15:0]}};
            default:                               wdata = m_rs2_data;
        endcase
    end

    assign mal_l = m_valid && m_dren && mal_addr;
    assign mal_s = m_valid && m_dwen && mal_addr;

    // No bus traffic for a misaligned access
    assign ren = m_valid && m_dren && !mal_addr;
    assign wen = m_valid && m_dwen && !mal_addr;

    assign stall = busy;

    assign wb_valid = m_valid && m_reg_write && !mal_addr && !busy;
    assign wb_rd    = m_rd;

    always_comb begin
        case (m_wb_sel)
            mem_types_pkg::WB_LOAD:  wb_data = load_data;
            mem_types_pkg::WB_PC4:   wb_data = m_pc4;
            mem_types_pkg::WB_IMM_U: wb_data = m_imm_u;
            default:                 wb_data = m_alu_out;
        endcase
    end

    // Bus requests only with a legal lane pattern
    // A write's lowest enabled lane is the addressed byte
    always_comb begin
        a_no_mal_write: assert final (!wen || (byte_en[offset] &&
                ((byte_en & ((4'b0001 << offset) - 4'b0001)) == 4'b0000)))
            else $error("write issued for a misaligned store");
        a_lanes_set: assert final (!(ren || wen) || (byte_en != '0))
            else $error("bus request with no byte lane enabled");
    end

endmodule

`default_nettype wire

// File: hdl/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_subsys_top (
    input  wire logic                     CLK,
    input  wire logic                     nRST,
    input  wire logic                     in_valid,
    input  wire logic                     in_dren,
    input  wire logic                     in_dwen,
    input  mem_types_pkg::mem_size_t      in_size,
    input  mem_types_pkg::wb_sel_t        in_wb_sel,
    input  wire logic                     in_reg_write,
    input  wire logic [`REG_IDX_W-1:0]    in_rd,
    input  wire logic [`DATA_W-1:0]       in_alu_out,
    input  wire logic [`DATA_W-1:0]       in_rs2_data,
    input  wire logic [`DATA_W-1:0]       in_pc4,
    input  wire logic [`DATA_W-1:0]       in_imm_u,
    output logic                          stall,
    output logic                          wb_valid,
    output logic [`REG_IDX_W-1:0]         wb_rd,
    output logic [`DATA_W-1:0]            wb_data,
    output logic                          mal_l,
    output logic                          mal_s
);

    // Pipeline register outputs
    logic                      m_valid, m_dren, m_dwen, m_reg_write;
    mem_types_pkg::mem_size_t  m_size;
    mem_types_pkg::wb_sel_t    m_wb_sel;
    logic [`REG_IDX_W-1:0]     m_rd;
    logic [`DATA_W-1:0]        m_alu_out, m_rs2_data, m_pc4, m_imm_u;

    // Data bus and load path
    logic                      ren, wen, busy;
    logic [`RAM_ADDR_BITS-1:0] addr;
    logic [`DATA_W/8-1:0]      byte_en;
    logic [`DATA_W-1:0]        wdata, rdata, load_data;

    ex_mem_reg u_ex_mem_reg (
        .CLK, .nRST, .stall, .in_valid, .in_dren, .in_dwen, .in_size, .in_wb_sel,
        .in_reg_write, .in_rd, .in_alu_out, .in_rs2_data, .in_pc4, .in_imm_u,
        .m_valid, .m_dren, .m_dwen, .m_size, .m_wb_sel, .m_reg_write, .m_rd,
        .m_alu_out, .m_rs2_data, .m_pc4, .m_imm_u
    );

    mem_stage u_mem_stage (
        .m_valid, .m_dren, .m_dwen, .m_size, .m_wb_sel, .m_reg_write, .m_rd,
        .m_alu_out, .m_rs2_data, .m_pc4, .m_imm_u, .busy, .load_data,
        .ren, .wen, .addr, .byte_en, .wdata, .stall,
        .wb_valid, .wb_rd, .wb_data, .mal_l, .mal_s
    );

    load_extender u_load_extender (
        .rdata     (rdata),
        .size      (m_size),
        .offset    (m_alu_out[1:0]),
        .load_data (load_data)
    );

    data_ram #(
        .ADDR_BITS (`RAM_ADDR_BITS)
    ) u_data_ram (
        .CLK, .nRST, .ren, .wen, .addr, .byte_en, .wdata, .rdata, .busy
    );

endmodule

`default_nettype wire

// File: hdl/mem_types_pkg.sv
`default_nettype none

package mem_types_pkg;

    // Access width and signedness, funct3 encoding of RV32 loads
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } mem_size_t;

    // Source of the register writeback value
    typedef enum logic [1:0] {
        WB_LOAD  = 2'd0,
        WB_PC4   = 2'd1,
        WB_IMM_U = 2'd2,
        WB_ALU   = 2'd3
    } wb_sel_t;

    // One data word seen as byte lanes or as halfwords
    // Lane 0 is the least significant byte (little-endian bus)
    typedef union packed {
        logic [3:0][7:0]  lanes;
        logic [1:0][15:0] halves;
    } data_word_u;

endpackage

`default_nettype wire

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic CLK,
    output logic nRST
);

    // 10 ns period
    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Reset held low for three rising edges
    initial begin
        nRST = 1'b0;
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

`default_nettype wire

// File: test/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module tb_mem_subsys;

    localparam int MEM_BYTES = 4 * (2 ** `RAM_ADDR_BITS);
    localparam int OP_ALU    = 0;
    localparam int OP_LOAD   = 1;
    localparam int OP_STORE  = 2;

    typedef struct {
        string                    name;
        int                       op;
        mem_types_pkg::mem_size_t size;
        mem_types_pkg::wb_sel_t   wb_sel;
        logic                     reg_write;
        logic [`REG_IDX_W-1:0]    rd;
        logic [`DATA_W-1:0]       addr, wdata, pc4, imm_u, exp_data;
        logic                     exp_wb, exp_mal;
    } row_t;

    logic                     CLK, nRST, in_valid, in_dren, in_dwen, in_reg_write;
    mem_types_pkg::mem_size_t in_size;
    mem_types_pkg::wb_sel_t   in_wb_sel;
    logic [`REG_IDX_W-1:0]    in_rd, wb_rd;
    logic [`DATA_W-1:0]       in_alu_out, in_rs2_data, in_pc4, in_imm_u, wb_data;
    logic                     stall, wb_valid, mal_l, mal_s;

    row_t       rows[$];
    row_t       prev;
    logic [7:0] shadow [MEM_BYTES];
    logic       pending;
    integer     seed = 32'h42b40f95;
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    int         cycle_limit = 0;

    tb_clk_gen u_clk_gen (.CLK, .nRST);

    mem_subsys_top u_dut (
        .CLK, .nRST, .in_valid, .in_dren, .in_dwen, .in_size, .in_wb_sel, .in_reg_write,
        .in_rd, .in_alu_out, .in_rs2_data, .in_pc4, .in_imm_u,
        .stall, .wb_valid, .wb_rd, .wb_data, .mal_l, .mal_s
    );

    function automatic logic is_misaligned(mem_types_pkg::mem_size_t size,
                                           logic [`DATA_W-1:0] a);
        case (size)
            mem_types_pkg::LH, mem_types_pkg::LHU: return a[0];
            mem_types_pkg::LW:                     return a[1:0] != 2'b00;
            default:                               return 1'b0;
        endcase
    endfunction

    // Little-endian read of the shadow bytes, then sign or zero fill
    function automatic logic [`DATA_W-1:0] model_load(mem_types_pkg::mem_size_t size,
                                                      logic [`DATA_W-1:0] a);
        int b;
        b = int'(a[`RAM_ADDR_BITS+1:0]);
        case (size)
            mem_types_pkg::LB:  return {{24{shadow[b][7]}}, shadow[b]};
            mem_types_pkg::LBU: return {24'h0, shadow[b]};
            mem_types_pkg::LH:  return {{16{shadow[b+1][7]}}, shadow[b+1], shadow[b]};
            mem_types_pkg::LHU: return {16'h0, shadow[b+1], shadow[b]};
            default:            return {shadow[b+3], shadow[b+2], shadow[b+1], shadow[b]};
        endcase
    endfunction

    function automatic void model_store(mem_types_pkg::mem_size_t size,
                                        logic [`DATA_W-1:0] a, logic [`DATA_W-1:0] d);
        int b;
        int n;
        b = int'(a[`RAM_ADDR_BITS+1:0]);
        n = (size == mem_types_pkg::LW) ? 4 : (size == mem_types_pkg::LH) ? 2 : 1;
        for (int i = 0; i < n; i++) begin
            shadow[b+i] = d[8*i +: 8];
        end
    endfunction

    // Expected values come from the shadow model in program order
    function automatic void add_row(string name, int op, mem_types_pkg::mem_size_t size,
                                    mem_types_pkg::wb_sel_t sel, logic reg_write,
                                    logic [`REG_IDX_W-1:0] rd, logic [`DATA_W-1:0] a,
                                    logic [`DATA_W-1:0] d, logic [`DATA_W-1:0] pc4,
                                    logic [`DATA_W-1:0] imm);
        row_t r;
        r = '{name, op, size, sel, reg_write, rd, a, d, pc4, imm, '0, 1'b0, 1'b0};
        r.exp_mal = (op != OP_ALU) && is_misaligned(size, a);
        r.exp_wb  = reg_write && !r.exp_mal;
        if (op == OP_LOAD && !r.exp_mal) begin
            r.exp_data = model_load(size, a);
        end else if (op == OP_STORE && !r.exp_mal) begin
            model_store(size, a, d);
        end else if (op == OP_ALU) begin
            r.exp_data = (sel == mem_types_pkg::WB_PC4) ? pc4 :
                         (sel == mem_types_pkg::WB_IMM_U) ? imm : a;
        end
        rows.push_back(r);
    endfunction

    function automatic void add_load(string name, mem_types_pkg::mem_size_t size,
                                     logic [`DATA_W-1:0] a, logic [`REG_IDX_W-1:0] rd);
        add_row(name, OP_LOAD, size, mem_types_pkg::WB_LOAD, 1'b1, rd, a, '0,
                32'h0000_1004, 32'hABCD_E000);
    endfunction

    function automatic void add_store(string name, mem_types_pkg::mem_size_t size,
                                      logic [`DATA_W-1:0] a, logic [`DATA_W-1:0] d);
        add_row(name, OP_STORE, size, mem_types_pkg::WB_ALU, 1'b0, 5'd0, a, d, '0, '0);
    endfunction

    // Every size and signedness at every aligned offset of one word
    function automatic void load_sweep(logic [`DATA_W-1:0] base, logic [`REG_IDX_W-1:0] rd);
        add_load($sformatf("lw_%0h", base), mem_types_pkg::LW, base, rd);
        for (int o = 0; o < 4; o += 2) begin
            add_load($sformatf("lh_%0h", base + o), mem_types_pkg::LH, base + o, rd);
            add_load($sformatf("lhu_%0h", base + o), mem_types_pkg::LHU, base + o, rd);
        end
        for (int o = 0; o < 4; o++) begin
            add_load($sformatf("lb_%0h", base + o), mem_types_pkg::LB, base + o, rd);
            add_load($sformatf("lbu_%0h", base + o), mem_types_pkg::LBU, base + o, rd);
        end
    endfunction

    function automatic void build_table();
        logic [`DATA_W-1:0] r;
        logic [`DATA_W-1:0] a;
        add_store("sb_100", mem_types_pkg::LB, 32'h100, 32'hAABBCCF1);
        add_store("sb_101", mem_types_pkg::LB, 32'h101, 32'h11223372);
        add_store("sb_102", mem_types_pkg::LB, 32'h102, 32'h00000093);
        add_store("sb_103", mem_types_pkg::LB, 32'h103, 32'h5A5A5A04);
        load_sweep(32'h100, 5'd5);
        add_store("sh_104", mem_types_pkg::LH, 32'h104, 32'h12348001);
        add_store("sh_106", mem_types_pkg::LH, 32'h106, 32'hDEAD7FFE);
        load_sweep(32'h104, 5'd6);
        add_store("sw_108", mem_types_pkg::LW, 32'h108, 32'hC0DEF00D);
        load_sweep(32'h108, 5'd7);
        // Misaligned accesses, then proof that memory is untouched
        add_load("lh_mal_109", mem_types_pkg::LH, 32'h109, 5'd8);
        add_load("lhu_mal_10b", mem_types_pkg::LHU, 32'h10B, 5'd8);
        add_load("lw_mal_10a", mem_types_pkg::LW, 32'h10A, 5'd8);
        add_store("sh_mal_109", mem_types_pkg::LH, 32'h109, 32'hFFFFFFFF);
        add_store("sw_mal_102", mem_types_pkg::LW, 32'h102, 32'hDEADBEEF);
        add_store("sw_mal_10b", mem_types_pkg::LW, 32'h10B, 32'h01234567);
        load_sweep(32'h100, 5'd9);
        add_load("lw_108_after", mem_types_pkg::LW, 32'h108, 5'd9);
        add_row("alu_pc4", OP_ALU, mem_types_pkg::LB, mem_types_pkg::WB_PC4, 1'b1, 5'd1,
                32'h0000_0043, '0, 32'h0000_2008, 32'h1234_5000);
        add_row("alu_imm_u", OP_ALU, mem_types_pkg::LB, mem_types_pkg::WB_IMM_U, 1'b1, 5'd2,
                32'h0000_0043, '0, 32'h0000_2008, 32'h1234_5000);
        add_row("alu_alu", OP_ALU, mem_types_pkg::LB, mem_types_pkg::WB_ALU, 1'b1, 5'd3,
                32'h8765_4321, '0, 32'h0000_2008, 32'h1234_5000);
        add_row("alu_no_write", OP_ALU, mem_types_pkg::LB, mem_types_pkg::WB_ALU, 1'b0, 5'd4,
                32'h0F0F_0F0F, '0, 32'h0000_2008, 32'h1234_5000);
        // Random region is filled first so no load sees an unwritten word
        for (int k = 0; k < 16; k++) begin
            add_store($sformatf("rnd_init_%0d", k), mem_types_pkg::LW, 32'h200 + 4 * k,
                      $random(seed));
        end
        for (int k = 0; k < 50; k++) begin
            r = $random(seed);
            a = 32'h200 + {r[7:4], 2'b00};
            case (r[1:0])
                2'd0: add_store($sformatf("rnd_sw_%0d", k), mem_types_pkg::LW, a, $random(seed));
                2'd1: add_store($sformatf("rnd_sb_%0d", k), mem_types_pkg::LB, a + r[9:8],
                                $random(seed));
                2'd2: add_load($sformatf("rnd_lw_%0d", k), mem_types_pkg::LW, a, 5'(k % 31 + 1));
                default: add_load($sformatf("rnd_lb_%0d", k),
                                  r[10] ? mem_types_pkg::LBU : mem_types_pkg::LB,
                                  a + r[9:8], 5'(k % 31 + 1));
            endcase
        end
    endfunction

    task automatic check_value(string test, string what, logic [`DATA_W-1:0] exp,
                               logic [`DATA_W-1:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", test, what, exp, act);
        end
    endtask

    task automatic check_outputs(row_t r, string phase, logic exp_stall, logic exp_wb,
                                 logic exp_ml, logic exp_ms);
        string tag;
        tag = {r.name, phase};
        check_value(tag, "stall", exp_stall, stall);
        check_value(tag, "wb_valid", exp_wb, wb_valid);
        check_value(tag, "mal_l", exp_ml, mal_l);
        check_value(tag, "mal_s", exp_ms, mal_s);
        if (exp_wb) begin
            check_value(tag, "wb_data", r.exp_data, wb_data);
            check_value(tag, "wb_rd", r.rd, wb_rd);
        end
    endtask

    task automatic drive_row(row_t r);
        in_valid     <= 1'b1;
        in_dren      <= (r.op == OP_LOAD);
        in_dwen      <= (r.op == OP_STORE);
        in_size      <= r.size;
        in_wb_sel    <= r.wb_sel;
        in_reg_write <= r.reg_write;
        in_rd        <= r.rd;
        in_alu_out   <= r.addr;
        in_rs2_data  <= r.wdata;
        in_pc4       <= r.pc4;
        in_imm_u     <= r.imm_u;
    endtask

    // Each row needs at most two cycles, doubled for margin
    always @(posedge CLK) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: the rows did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        in_valid     = 1'b0;
        in_dren      = 1'b0;
        in_dwen      = 1'b0;
        in_size      = mem_types_pkg::LW;
        in_wb_sel    = mem_types_pkg::WB_ALU;
        in_reg_write = 1'b0;
        in_rd        = '0;
        in_alu_out   = '0;
        in_rs2_data  = '0;
        in_pc4       = '0;
        in_imm_u     = '0;
        pending      = 1'b0;
        build_table();
        cycle_limit = 2 * rows.size() * 2 + 3;
        @(posedge nRST);
        @(negedge CLK);
        check_value("reset", "stall", 1'b0, stall);
        check_value("reset", "wb_valid", 1'b0, wb_valid);
        check_value("reset", "mal_l", 1'b0, mal_l);
        check_value("reset", "mal_s", 1'b0, mal_s);
        foreach (rows[i]) begin
            @(posedge CLK);
            drive_row(rows[i]);
            @(negedge CLK);
            // Second cycle of the previous memory access
            if (pending) begin
                check_outputs(prev, " c2", 1'b0, prev.exp_wb, 1'b0, 1'b0);
            end
            while (stall) @(negedge CLK);
            @(posedge CLK);
            in_valid <= 1'b0;
            @(negedge CLK);
            pending = (rows[i].op != OP_ALU) && !rows[i].exp_mal;
            check_outputs(rows[i], " c1", pending, pending ? 1'b0 : rows[i].exp_wb,
                          rows[i].op == OP_LOAD && rows[i].exp_mal,
                          rows[i].op == OP_STORE && rows[i].exp_mal);
            prev = rows[i];
        end
        if (pending) begin
            @(posedge CLK);
            @(negedge CLK);
            check_outputs(prev, " c2", 1'b0, prev.exp_wb, 1'b0, 1'b0);
        end
        $display("Rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
